// File: dm_settings.svh
// debug module settings: hart count, field widths, fixed fields and register map
`ifndef DM_SETTINGS_SVH
`define DM_SETTINGS_SVH

// hart count and field widths
`define DM_NUM_HARTS 1
`define DM_ADDR_W 8
`define DM_DATA_W 32
`define DM_HARTSEL_W 10
`define DM_REGNO_W 16
`define DM_XLEN 64

// fixed values reported to the host
`define DM_VERSION 2
`define DM_DATACOUNT 2

// word addresses of the implemented registers
`define DM_ADDR_DATA0 8'h04
`define DM_ADDR_DATA1 8'h05
`define DM_ADDR_DMCONTROL 8'h10
`define DM_ADDR_DMSTATUS 8'h11
`define DM_ADDR_ABSTRACTCS 8'h16
`define DM_ADDR_COMMAND 8'h17

`endif

// File: dm_pkg.sv
// debug module shared types: vectors, register strobes, status bundles and command states
`include "dm_settings.svh"

package dm_pkg;

	// plain vectors with a meaning
	typedef logic [`DM_ADDR_W-1:0] dm_addr_t;
	typedef logic [`DM_DATA_W-1:0] dm_word_t;
	typedef logic [`DM_NUM_HARTS-1:0] hart_vec_t;
	typedef logic [`DM_HARTSEL_W-1:0] hartsel_t;
	typedef logic [`DM_REGNO_W-1:0] regno_t;
	typedef logic [`DM_XLEN-1:0] xlen_t;
	typedef logic [2:0] cmderr_t;

	// one accepted bus write, valid for a single cycle
	typedef struct packed {
		logic valid;
		dm_addr_t addr;
		dm_word_t data;
	} reg_wr_t;

	// dmcontrol write, fields already unpacked
	typedef struct packed {
		logic valid;
		logic haltreq;
		logic resumereq;
		logic hartreset;
		logic ackhavereset;
		hartsel_t hartsel;
		logic setresethaltreq;
		logic clrresethaltreq;
		logic ndmreset;
		logic dmactive;
	} dmcontrol_wr_t;

	// writes seen by the abstract command block
	typedef struct packed {
		logic cmd_valid;
		logic [7:0] cmdtype;
		logic [2:0] aarsize;
		logic transfer;
		logic write;
		regno_t regno;
		logic abscs_valid;
		// write-1-to-clear bits of cmderr
		cmderr_t cmderr_clr;
		logic data0_valid;
		logic data1_valid;
		dm_word_t data;
	} abs_wr_t;

	// member order is dmstatus bits 19 down to 8
	typedef struct packed {
		logic allhavereset;
		logic anyhavereset;
		logic allresumeack;
		logic anyresumeack;
		logic allnonexistent;
		logic anynonexistent;
		logic allunavail;
		logic anyunavail;
		logic allrunning;
		logic anyrunning;
		logic allhalted;
		logic anyhalted;
	} dmstatus_t;

	// readable part of dmcontrol
	typedef struct packed {
		logic hartreset;
		hartsel_t hartsel;
		logic ndmreset;
		logic dmactive;
	} dmcontrol_rd_t;

	typedef struct packed {
		logic busy;
		cmderr_t cmderr;
		dm_word_t data0;
		dm_word_t data1;
	} abs_rd_t;

	// access register request to the core
	typedef struct packed {
		regno_t regno;
		logic write;
		logic is32w;
		xlen_t wdata;
	} core_reg_req_t;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_CORE
	} abs_state_t;

endpackage

// File: dm_axil_slave.sv
// AXI4-Lite slave turning bus transactions into register write strobes and read lookups
`timescale 1ns/1ps

module dm_axil_slave (
	input logic CLK,
	input logic RSTn,
	input dm_pkg::dm_addr_t S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input dm_pkg::dm_word_t S_AXI_WDATA,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input dm_pkg::dm_addr_t S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output dm_pkg::dm_word_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	input dm_pkg::dm_word_t rd_data,
	output dm_pkg::reg_wr_t wr,
	output dm_pkg::dm_addr_t rd_addr
);

	logic wr_ready;
	// set at acceptance, dropped once the response is taken
	logic wr_pend;
	logic wr_hs;
	logic rd_hs;

	// aw and w are always taken together
	assign S_AXI_AWREADY = wr_ready;
	assign S_AXI_WREADY = wr_ready;
	assign wr_hs = wr_ready & S_AXI_AWVALID & S_AXI_WVALID;
	assign rd_hs = S_AXI_ARREADY & S_AXI_ARVALID;

	// always OKAY
	assign S_AXI_BRESP = 2'b00;
	assign S_AXI_RRESP = 2'b00;

	// strobe in the handshake cycle, address and data straight from the bus
	assign wr = '{valid: wr_hs, addr: S_AXI_AWADDR, data: S_AXI_WDATA};
	assign rd_addr = S_AXI_ARADDR;

	// one-cycle ready, blocked while a write is outstanding
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			wr_ready <= 1'b0;
			wr_pend <= 1'b0;
		end else if (!wr_ready && !wr_pend && S_AXI_AWVALID && S_AXI_WVALID) begin
			wr_ready <= 1'b1;
			wr_pend <= 1'b1;
		end else begin
			wr_ready <= 1'b0;
			if (S_AXI_BVALID && S_AXI_BREADY)
				wr_pend <= 1'b0;
		end
	end

	// response held until the host takes it
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn)
			S_AXI_BVALID <= 1'b0;
		else if (wr_hs)
			S_AXI_BVALID <= 1'b1;
		else if (S_AXI_BREADY)
			S_AXI_BVALID <= 1'b0;
	end

	// read side, no new address while data waits
	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			S_AXI_ARREADY <= 1'b0;
			S_AXI_RVALID <= 1'b0;
		end else begin
			S_AXI_ARREADY <= !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;
			if (rd_hs)
				S_AXI_RVALID <= 1'b1;
			else if (S_AXI_RREADY)
				S_AXI_RVALID <= 1'b0;
		end
	end

	// read data sampled at acceptance
	always_ff @(posedge CLK) begin
		if (rd_hs)
			S_AXI_RDATA <= rd_data;
	end

endmodule

// File: dm_reg_decode.sv
// register write decoder splitting bus strobes into dmcontrol and abstract command writes
`timescale 1ns/1ps
`include "dm_settings.svh"

module dm_reg_decode (
	input dm_pkg::reg_wr_t wr,
	output dm_pkg::dmcontrol_wr_t ctrl_wr,
	output dm_pkg::abs_wr_t abs_wr
);

	// dmcontrol bit fields
	always_comb begin
		ctrl_wr.valid = wr.valid && (wr.addr == `DM_ADDR_DMCONTROL);
		ctrl_wr.haltreq = wr.data[31];
		ctrl_wr.resumereq = wr.data[30];
		ctrl_wr.hartreset = wr.data[29];
		ctrl_wr.ackhavereset = wr.data[28];
		// hartsello only
		ctrl_wr.hartsel = wr.data[25:16];
		ctrl_wr.setresethaltreq = wr.data[3];
		ctrl_wr.clrresethaltreq = wr.data[2];
		ctrl_wr.ndmreset = wr.data[1];
		ctrl_wr.dmactive = wr.data[0];
	end

	// command, abstractcs and data strobes
	always_comb begin
		abs_wr.cmd_valid = wr.valid && (wr.addr == `DM_ADDR_COMMAND);
		abs_wr.cmdtype = wr.data[31:24];
		abs_wr.aarsize = wr.data[22:20];
		abs_wr.transfer = wr.data[17];
		abs_wr.write = wr.data[16];
		abs_wr.regno = wr.data[15:0];
		abs_wr.abscs_valid = wr.valid && (wr.addr == `DM_ADDR_ABSTRACTCS);
		// cmderr sits in abstractcs 10:8
		abs_wr.cmderr_clr = wr.data[10:8];
		abs_wr.data0_valid = wr.valid && (wr.addr == `DM_ADDR_DATA0);
		abs_wr.data1_valid = wr.valid && (wr.addr == `DM_ADDR_DATA1);
		abs_wr.data = wr.data;
	end

endmodule

// File: dm_hart_ctrl.sv
// hart control: dmcontrol state, hart request outputs and dmstatus summaries
`timescale 1ns/1ps
`include "dm_settings.svh"

module dm_hart_ctrl (
	input logic CLK,
	input logic RSTn,
	input dm_pkg::dmcontrol_wr_t ctrl_wr,
	input dm_pkg::hart_vec_t hart_in_reset,
	input dm_pkg::hart_vec_t hart_halted,
	output dm_pkg::hart_vec_t hart_halt_req,
	output dm_pkg::hart_vec_t hart_resume_req,
	output dm_pkg::hart_vec_t hart_reset_req,
	output dm_pkg::hart_vec_t hart_halt_on_reset,
	output logic ndmreset,
	output logic dmactive,
	output dm_pkg::dmstatus_t status,
	output dm_pkg::dmcontrol_rd_t ctrl_rd
);

	logic haltreq_q;
	logic hartreset_q;
	logic resume_q;
	logic halt_on_reset_q;
	dm_pkg::hartsel_t hartsel_q;
	dm_pkg::hart_vec_t havereset_q;
	dm_pkg::hart_vec_t resumeack_q;
	dm_pkg::hart_vec_t resume_pend_q;
	dm_pkg::hart_vec_t sel;
	dm_pkg::hart_vec_t wr_sel;
	dm_pkg::hart_vec_t resume_mask;
	dm_pkg::hart_vec_t ack_mask;
	dm_pkg::hart_vec_t running;
	logic active_nxt;
	logic wr_en;
	logic in_range;

	// one-hot of the hart with this index
	function automatic dm_pkg::hart_vec_t sel_of(input dm_pkg::hartsel_t h);
		dm_pkg::hart_vec_t s;
		s = '0;
		for (int i = 0; i < `DM_NUM_HARTS; i++)
			s[i] = (h == dm_pkg::hartsel_t'(i));
		return s;
	endfunction

	// all selected harts have v, zero when none is selected
	function automatic logic all_of(input dm_pkg::hart_vec_t v, input dm_pkg::hart_vec_t s);
		return (|s) & (&(v | ~s));
	endfunction

	// a write clearing dmactive clears the rest on the same edge
	assign active_nxt = ctrl_wr.valid ? ctrl_wr.dmactive : dmactive;
	// other fields only count when the write keeps or sets dmactive
	assign wr_en = ctrl_wr.valid & ctrl_wr.dmactive;
	assign sel = sel_of(hartsel_q);
	// written hartsel applies to the acks of its own write
	assign wr_sel = sel_of(ctrl_wr.hartsel);
	assign resume_mask = {`DM_NUM_HARTS{wr_en & ctrl_wr.resumereq & ~ctrl_wr.haltreq}} & wr_sel;
	assign ack_mask = {`DM_NUM_HARTS{wr_en & ctrl_wr.ackhavereset}} & wr_sel;
	assign in_range = (hartsel_q < `DM_NUM_HARTS);

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn)
			dmactive <= 1'b0;
		else if (ctrl_wr.valid)
			dmactive <= ctrl_wr.dmactive;
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			haltreq_q <= 1'b0;
			hartreset_q <= 1'b0;
			ndmreset <= 1'b0;
			hartsel_q <= '0;
			halt_on_reset_q <= 1'b0;
			resume_q <= 1'b0;
			havereset_q <= '0;
			resumeack_q <= '0;
			resume_pend_q <= '0;
		end else if (!active_nxt) begin
			haltreq_q <= 1'b0;
			hartreset_q <= 1'b0;
			ndmreset <= 1'b0;
			hartsel_q <= '0;
			halt_on_reset_q <= 1'b0;
			resume_q <= 1'b0;
			havereset_q <= '0;
			resumeack_q <= '0;
			resume_pend_q <= '0;
		end else begin
			// levels
			if (wr_en) begin
				haltreq_q <= ctrl_wr.haltreq;
				hartreset_q <= ctrl_wr.hartreset;
				ndmreset <= ctrl_wr.ndmreset;
				hartsel_q <= ctrl_wr.hartsel;
				// clear wins over set
				if (ctrl_wr.clrresethaltreq)
					halt_on_reset_q <= 1'b0;
				else if (ctrl_wr.setresethaltreq)
					halt_on_reset_q <= 1'b1;
			end
			// resume pulse for one cycle
			resume_q <= |resume_mask;
			havereset_q <= (havereset_q | hart_in_reset) & ~ack_mask;
			// pending resume acks once the hart leaves halt
			resumeack_q <= (resumeack_q | (resume_pend_q & ~hart_halted)) & ~resume_mask;
			resume_pend_q <= (resume_pend_q & hart_halted) | resume_mask;
		end
	end

	assign hart_halt_req = {`DM_NUM_HARTS{haltreq_q}} & sel;
	assign hart_resume_req = {`DM_NUM_HARTS{resume_q}} & sel;
	assign hart_reset_req = {`DM_NUM_HARTS{hartreset_q}} & sel;
	assign hart_halt_on_reset = {`DM_NUM_HARTS{halt_on_reset_q}} & sel;

	// status summaries over the selected harts
	assign running = ~hart_halted & ~hart_in_reset;
	assign status.allhavereset = all_of(havereset_q, sel);
	assign status.anyhavereset = |(havereset_q & sel);
	assign status.allresumeack = all_of(resumeack_q, sel);
	assign status.anyresumeack = |(resumeack_q & sel);
	assign status.allnonexistent = ~in_range;
	assign status.anynonexistent = ~in_range;
	assign status.allunavail = all_of(hart_in_reset, sel);
	assign status.anyunavail = |(hart_in_reset & sel);
	assign status.allrunning = all_of(running, sel);
	assign status.anyrunning = |(running & sel);
	assign status.allhalted = all_of(hart_halted, sel);
	assign status.anyhalted = |(hart_halted & sel);

	assign ctrl_rd = '{hartreset: hartreset_q, hartsel: hartsel_q, ndmreset: ndmreset,
		dmactive: dmactive};

endmodule

// File: dm_abstract_cmd.sv
// abstract command engine: access register requests, data0/data1 and cmderr
`timescale 1ns/1ps

module dm_abstract_cmd (
	input logic CLK,
	input logic RSTn,
	input logic dmactive,
	input dm_pkg::abs_wr_t abs_wr,
	input logic any_halted,
	input logic core_req_ready,
	input dm_pkg::xlen_t core_rdata,
	output logic core_req_valid,
	output dm_pkg::core_reg_req_t core_req,
	output dm_pkg::abs_rd_t abs_rd
);

	dm_pkg::abs_state_t state;
	dm_pkg::cmderr_t cmderr;
	dm_pkg::dm_word_t data0;
	dm_pkg::dm_word_t data1;
	logic busy;
	logic any_wr;
	logic bad_cmd;

	assign busy = (state == dm_pkg::WAIT_CORE);
	assign core_req_valid = busy;
	// every register that collides with a running command
	assign any_wr = abs_wr.cmd_valid | abs_wr.abscs_valid | abs_wr.data0_valid
		| abs_wr.data1_valid;
	// access register only, 32 or 64 bit when transferring
	assign bad_cmd = (abs_wr.cmdtype != 8'd0)
		|| (abs_wr.transfer && (abs_wr.aarsize != 3'd2) && (abs_wr.aarsize != 3'd3));

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			state <= dm_pkg::IDLE;
			cmderr <= '0;
			data0 <= '0;
			data1 <= '0;
		end else if (!dmactive) begin
			state <= dm_pkg::IDLE;
			cmderr <= '0;
			data0 <= '0;
			data1 <= '0;
		end else if (busy) begin
			// busy error, the write itself is dropped
			if (any_wr)
				cmderr <= 3'd1;
			if (core_req_ready) begin
				state <= dm_pkg::IDLE;
				// read result, high word only for 64 bit
				if (!core_req.write) begin
					data0 <= core_rdata[31:0];
					if (!core_req.is32w)
						data1 <= core_rdata[63:32];
				end
			end
		end else begin
			if (abs_wr.data0_valid)
				data0 <= abs_wr.data;
			if (abs_wr.data1_valid)
				data1 <= abs_wr.data;
			if (abs_wr.abscs_valid)
				cmderr <= cmderr & ~abs_wr.cmderr_clr;
			// new command only with a clean cmderr
			if (abs_wr.cmd_valid && (cmderr == 3'd0)) begin
				if (bad_cmd)
					cmderr <= 3'd2;
				else if (!any_halted)
					cmderr <= 3'd4;
				else if (abs_wr.transfer)
					state <= dm_pkg::WAIT_CORE;
			end
		end
	end

	// request fields captured with the command, held while waiting
	always_ff @(posedge CLK) begin
		if (!busy && abs_wr.cmd_valid) begin
			core_req.regno <= abs_wr.regno;
			core_req.write <= abs_wr.write;
			core_req.is32w <= (abs_wr.aarsize == 3'd2);
			core_req.wdata <= {data1, data0};
		end
	end

	assign abs_rd = '{busy: busy, cmderr: cmderr, data0: data0, data1: data1};

endmodule

// File: dm_read_mux.sv
// readback mux building the addressed register word with its fixed fields
`timescale 1ns/1ps
`include "dm_settings.svh"

module dm_read_mux (
	input dm_pkg::dm_addr_t rd_addr,
	input dm_pkg::dmstatus_t status,
	input dm_pkg::dmcontrol_rd_t ctrl_rd,
	input dm_pkg::abs_rd_t abs_rd,
	output dm_pkg::dm_word_t rd_data
);

	dm_pkg::dm_word_t dmstatus_w;
	dm_pkg::dm_word_t dmcontrol_w;
	dm_pkg::dm_word_t abstractcs_w;

	// impebreak 0, authenticated and hasresethaltreq set, no confstrptr
	assign dmstatus_w = {12'b0, status, 1'b1, 1'b0, 1'b1, 1'b0, 4'(`DM_VERSION)};

	// write-only bits and hartselhi read 0
	assign dmcontrol_w = {2'b0, ctrl_rd.hartreset, 3'b0, ctrl_rd.hartsel, 14'b0,
		ctrl_rd.ndmreset, ctrl_rd.dmactive};

	// no program buffer
	assign abstractcs_w = {3'b0, 5'd0, 11'b0, abs_rd.busy, 1'b0, abs_rd.cmderr, 4'b0,
		4'(`DM_DATACOUNT)};

	always_comb begin
		case (rd_addr)
			`DM_ADDR_DATA0: rd_data = abs_rd.data0;
			`DM_ADDR_DATA1: rd_data = abs_rd.data1;
			`DM_ADDR_DMCONTROL: rd_data = dmcontrol_w;
			`DM_ADDR_DMSTATUS: rd_data = dmstatus_w;
			`DM_ADDR_ABSTRACTCS: rd_data = abstractcs_w;
			// command and unmapped addresses
			default: rd_data = '0;
		endcase
	end

endmodule

// File: dm_top.sv
// debug module top: AXI4-Lite front end, write decode, hart control, commands and readback
`timescale 1ns/1ps

module dm_top (
	input logic CLK,
	input logic RSTn,
	input dm_pkg::dm_addr_t S_AXI_AWADDR,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input dm_pkg::dm_word_t S_AXI_WDATA,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input dm_pkg::dm_addr_t S_AXI_ARADDR,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output dm_pkg::dm_word_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	output logic ndmreset,
	output logic dmactive,
	output dm_pkg::hart_vec_t hart_halt_req,
	output dm_pkg::hart_vec_t hart_resume_req,
	output dm_pkg::hart_vec_t hart_reset_req,
	output dm_pkg::hart_vec_t hart_halt_on_reset,
	input dm_pkg::hart_vec_t hart_in_reset,
	input dm_pkg::hart_vec_t hart_halted,
	output logic core_req_valid,
	output dm_pkg::core_reg_req_t core_req,
	input logic core_req_ready,
	input dm_pkg::xlen_t core_rdata
);

	dm_pkg::reg_wr_t wr;
	dm_pkg::dm_addr_t rd_addr;
	dm_pkg::dm_word_t rd_data;
	dm_pkg::dmcontrol_wr_t ctrl_wr;
	dm_pkg::abs_wr_t abs_wr;
	dm_pkg::dmstatus_t status;
	dm_pkg::dmcontrol_rd_t ctrl_rd;
	dm_pkg::abs_rd_t abs_rd;

	// bus front end, kept alive while dmactive is low
	dm_axil_slave u_axil (
		.CLK(CLK), .RSTn(RSTn),
		.S_AXI_AWADDR(S_AXI_AWADDR), .S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WDATA(S_AXI_WDATA), .S_AXI_WVALID(S_AXI_WVALID), .S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP), .S_AXI_BVALID(S_AXI_BVALID), .S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR), .S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA(S_AXI_RDATA), .S_AXI_RRESP(S_AXI_RRESP), .S_AXI_RVALID(S_AXI_RVALID),
		.S_AXI_RREADY(S_AXI_RREADY),
		.rd_data(rd_data), .wr(wr), .rd_addr(rd_addr)
	);

	dm_reg_decode u_decode (
		.wr(wr), .ctrl_wr(ctrl_wr), .abs_wr(abs_wr)
	);

	dm_hart_ctrl u_hart (
		.CLK(CLK), .RSTn(RSTn), .ctrl_wr(ctrl_wr),
		.hart_in_reset(hart_in_reset), .hart_halted(hart_halted),
		.hart_halt_req(hart_halt_req), .hart_resume_req(hart_resume_req),
		.hart_reset_req(hart_reset_req), .hart_halt_on_reset(hart_halt_on_reset),
		.ndmreset(ndmreset), .dmactive(dmactive), .status(status), .ctrl_rd(ctrl_rd)
	);

	// commands gated by the halted summary of the selected hart
	dm_abstract_cmd u_abs (
		.CLK(CLK), .RSTn(RSTn), .dmactive(dmactive), .abs_wr(abs_wr),
		.any_halted(status.anyhalted), .core_req_ready(core_req_ready),
		.core_rdata(core_rdata), .core_req_valid(core_req_valid), .core_req(core_req),
		.abs_rd(abs_rd)
	);

	dm_read_mux u_rmux (
		.rd_addr(rd_addr), .status(status), .ctrl_rd(ctrl_rd), .abs_rd(abs_rd),
		.rd_data(rd_data)
	);

endmodule

// File: tb_dm_top.sv
// debug module testbench: AXI4-Lite host, core register model and reference readback model
`timescale 1ns/1ps
`include "dm_settings.svh"

module tb_dm_top;

	localparam int TIMEOUT_CYCLES = 100;

	logic CLK;
	logic RSTn;
	dm_pkg::dm_addr_t S_AXI_AWADDR;
	logic S_AXI_AWVALID;
	logic S_AXI_AWREADY;
	dm_pkg::dm_word_t S_AXI_WDATA;
	logic S_AXI_WVALID;
	logic S_AXI_WREADY;
	logic [1:0] S_AXI_BRESP;
	logic S_AXI_BVALID;
	logic S_AXI_BREADY;
	dm_pkg::dm_addr_t S_AXI_ARADDR;
	logic S_AXI_ARVALID;
	logic S_AXI_ARREADY;
	dm_pkg::dm_word_t S_AXI_RDATA;
	logic [1:0] S_AXI_RRESP;
	logic S_AXI_RVALID;
	logic S_AXI_RREADY;
	logic ndmreset;
	logic dmactive;
	dm_pkg::hart_vec_t hart_halt_req;
	dm_pkg::hart_vec_t hart_resume_req;
	dm_pkg::hart_vec_t hart_reset_req;
	dm_pkg::hart_vec_t hart_halt_on_reset;
	dm_pkg::hart_vec_t hart_in_reset;
	dm_pkg::hart_vec_t hart_halted;
	logic core_req_valid;
	dm_pkg::core_reg_req_t core_req;
	logic core_req_ready;
	dm_pkg::xlen_t core_rdata;

	// xorshift state
	logic [31:0] seed = 32'h21c3b58e;

	// core model
	dm_pkg::xlen_t core_regs [8];
	dm_pkg::core_reg_req_t exp_req;
	int core_count;
	logic slow_core;

	// reference model state
	logic m_active;
	logic m_haltreq;
	logic m_hartreset;
	logic m_ndmreset;
	logic m_hor;
	// resume pulse expected right after a dmcontrol write
	logic m_resume;
	dm_pkg::hartsel_t m_hartsel;
	logic m_havereset;
	logic m_resumeack;
	logic m_busy;
	dm_pkg::cmderr_t m_cmderr;
	dm_pkg::dm_word_t m_data0;
	dm_pkg::dm_word_t m_data1;
	// command waiting for the core
	int cmd_start;
	dm_pkg::regno_t pend_regno;
	logic [2:0] pend_size;
	logic pend_write;

	dm_top UUT (.*);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function logic [31:0] next_rand();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout while waiting for %s", what);
		abort_run();
	endtask

	task automatic check_word(input string name, input dm_pkg::dm_word_t got,
		input dm_pkg::dm_word_t exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_hart(input string name, input dm_pkg::hart_vec_t got,
		input dm_pkg::hart_vec_t exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_req(input string name, input dm_pkg::core_reg_req_t got,
		input dm_pkg::core_reg_req_t exp);
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// expected register word from the model and the hart inputs
	function automatic dm_pkg::dm_word_t exp_reg(input dm_pkg::dm_addr_t a);
		logic s;
		logic run;
		logic [11:0] st;
		dm_pkg::dm_word_t w;
		s = (m_hartsel < `DM_NUM_HARTS);
		run = !hart_halted[0] && !hart_in_reset[0];
		st = {s & m_havereset, s & m_havereset, s & m_resumeack, s & m_resumeack, !s, !s,
			s & hart_in_reset[0], s & hart_in_reset[0], s & run, s & run,
			s & hart_halted[0], s & hart_halted[0]};
		w = '0;
		case (a)
			`DM_ADDR_DMSTATUS: w = {12'b0, st, 8'b1010_0010};
			`DM_ADDR_DMCONTROL: w = {2'b0, m_hartreset, 3'b0, m_hartsel, 14'b0, m_ndmreset,
				m_active};
			`DM_ADDR_ABSTRACTCS: w = {19'b0, m_busy, 1'b0, m_cmderr, 8'h02};
			`DM_ADDR_DATA0: w = m_data0;
			`DM_ADDR_DATA1: w = m_data1;
			default: w = '0;
		endcase
		return w;
	endfunction

	task automatic model_clear();
		m_active = 1'b0;
		m_haltreq = 1'b0;
		m_hartreset = 1'b0;
		m_ndmreset = 1'b0;
		m_hor = 1'b0;
		m_resume = 1'b0;
		m_hartsel = '0;
		m_havereset = 1'b0;
		m_resumeack = 1'b0;
		m_busy = 1'b0;
		m_cmderr = '0;
		m_data0 = '0;
		m_data1 = '0;
	endtask

	// entered and left a fixed delay after a rising edge
	task automatic axi_write(input dm_pkg::dm_addr_t a, input dm_pkg::dm_word_t d);
		int n;
		S_AXI_AWADDR = a;
		S_AXI_WDATA = d;
		S_AXI_AWVALID = 1'b1;
		S_AXI_WVALID = 1'b1;
		n = 0;
		while (!S_AXI_AWREADY) begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT_CYCLES)
				report_timeout("write address acceptance");
		end
		// data channel accepted together with the address
		check_word("S_AXI_WREADY", 32'(S_AXI_WREADY), 32'h1);
		@(posedge CLK);
		#10;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID = 1'b0;
		n = 0;
		while (!S_AXI_BVALID) begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT_CYCLES)
				report_timeout("write response");
		end
		check_word("S_AXI_BRESP", 32'(S_AXI_BRESP), 32'h0);
	endtask

	task automatic axi_read(input dm_pkg::dm_addr_t a, output dm_pkg::dm_word_t d);
		int n;
		S_AXI_ARADDR = a;
		S_AXI_ARVALID = 1'b1;
		n = 0;
		while (!S_AXI_ARREADY) begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT_CYCLES)
				report_timeout("read address acceptance");
		end
		@(posedge CLK);
		#10;
		S_AXI_ARVALID = 1'b0;
		n = 0;
		while (!S_AXI_RVALID) begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT_CYCLES)
				report_timeout("read data");
		end
		check_word("S_AXI_RRESP", 32'(S_AXI_RRESP), 32'h0);
		d = S_AXI_RDATA;
		@(posedge CLK);
		#10;
	endtask

	task automatic check_reg(input string name, input dm_pkg::dm_addr_t a);
		dm_pkg::dm_word_t d;
		axi_read(a, d);
		check_word(name, d, exp_reg(a));
	endtask

	task automatic check_all();
		check_reg("dmstatus", `DM_ADDR_DMSTATUS);
		check_reg("dmcontrol", `DM_ADDR_DMCONTROL);
		check_reg("abstractcs", `DM_ADDR_ABSTRACTCS);
		check_reg("data0", `DM_ADDR_DATA0);
		check_reg("data1", `DM_ADDR_DATA1);
		check_reg("unmapped", 8'h20);
	endtask

	task automatic check_outputs();
		logic s;
		s = (m_hartsel < `DM_NUM_HARTS);
		check_hart("hart_halt_req", hart_halt_req, dm_pkg::hart_vec_t'(m_haltreq & s));
		check_hart("hart_reset_req", hart_reset_req, dm_pkg::hart_vec_t'(m_hartreset & s));
		check_hart("hart_halt_on_reset", hart_halt_on_reset, dm_pkg::hart_vec_t'(m_hor & s));
		check_hart("hart_resume_req", hart_resume_req, dm_pkg::hart_vec_t'(m_resume & s));
		check_word("dmactive", 32'(dmactive), 32'(m_active));
		check_word("ndmreset", 32'(ndmreset), 32'(m_ndmreset));
	endtask

	task automatic ctrl_write(input logic hr, input logic rr, input logic hrst, input logic ack,
		input dm_pkg::hartsel_t hs, input logic setr, input logic clrr, input logic ndm,
		input logic act);
		axi_write(`DM_ADDR_DMCONTROL, {hr, rr, hrst, ack, 2'b0, hs, 12'b0, setr, clrr, ndm, act});
		if (!act) begin
			model_clear();
		end else begin
			m_active = 1'b1;
			m_haltreq = hr;
			m_hartreset = hrst;
			m_ndmreset = ndm;
			m_hartsel = hs;
			m_resume = rr && !hr;
			if (clrr)
				m_hor = 1'b0;
			else if (setr)
				m_hor = 1'b1;
			if (ack && hs == 0)
				m_havereset = 1'b0;
			// ack follows once the hart is seen running
			if (rr && !hr && hs == 0)
				m_resumeack = !hart_halted[0];
		end
		check_outputs();
		// resume request lasts a single cycle
		@(posedge CLK);
		#10;
		m_resume = 1'b0;
		check_hart("hart_resume_req", hart_resume_req, '0);
	endtask

	task automatic data_write(input dm_pkg::dm_addr_t a, input dm_pkg::dm_word_t d);
		axi_write(a, d);
		if (m_busy)
			m_cmderr = 3'd1;
		else if (a == `DM_ADDR_DATA0)
			m_data0 = d;
		else
			m_data1 = d;
	endtask

	task automatic abscs_write(input dm_pkg::cmderr_t bits);
		axi_write(`DM_ADDR_ABSTRACTCS, {21'b0, bits, 8'b0});
		if (m_busy)
			m_cmderr = 3'd1;
		else
			m_cmderr = m_cmderr & ~bits;
	endtask

	task automatic complete_cmd();
		int n;
		n = 0;
		while (core_count < cmd_start + 1) begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT_CYCLES)
				report_timeout("core request completion");
		end
		@(posedge CLK);
		#10;
		m_busy = 1'b0;
		if (!pend_write) begin
			m_data0 = core_regs[pend_regno[2:0]][31:0];
			if (pend_size == 3'd3)
				m_data1 = core_regs[pend_regno[2:0]][63:32];
		end
	endtask

	// slow commands are left running for the caller to complete
	task automatic run_cmd(input logic [7:0] ct, input logic [2:0] sz, input logic tr,
		input logic wr, input dm_pkg::regno_t rn);
		logic go;
		go = 1'b0;
		exp_req = '{regno: rn, write: wr, is32w: (sz == 3'd2), wdata: {m_data1, m_data0}};
		cmd_start = core_count;
		pend_regno = rn;
		pend_size = sz;
		pend_write = wr;
		if (m_cmderr == 0) begin
			if (ct != 0 || (tr && sz != 3'd2 && sz != 3'd3))
				m_cmderr = 3'd2;
			else if (!(m_hartsel == 0 && hart_halted[0]))
				m_cmderr = 3'd4;
			else if (tr)
				go = 1'b1;
		end
		axi_write(`DM_ADDR_COMMAND, {ct, 1'b0, sz, 2'b0, tr, wr, rn});
		if (go) begin
			m_busy = 1'b1;
			if (!slow_core)
				complete_cmd();
		end
	endtask

	// core model, answers after a random delay and compares the request
	initial begin
		int delay;
		core_req_ready = 1'b0;
		core_rdata = '0;
		forever begin
			@(negedge CLK);
			if (core_req_valid) begin
				check_req("core_req", core_req, exp_req);
				if (slow_core)
					delay = 30;
				else
					delay = 1 + int'(next_rand() % 6);
				repeat (delay) @(posedge CLK);
				#10;
				core_req_ready = 1'b1;
				core_rdata = core_regs[core_req.regno[2:0]];
				if (core_req.write)
					core_regs[core_req.regno[2:0]] = core_req.wdata;
				@(posedge CLK);
				#10;
				core_req_ready = 1'b0;
				core_count++;
			end
		end
	end

	initial begin
		logic [2:0] sz;
		dm_pkg::dm_word_t d;
		RSTn = 1'b0;
		S_AXI_AWADDR = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA = '0;
		S_AXI_WVALID = 1'b0;
		S_AXI_BREADY = 1'b1;
		S_AXI_ARADDR = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY = 1'b1;
		hart_in_reset = '0;
		hart_halted = '0;
		core_count = 0;
		slow_core = 1'b0;
		exp_req = '0;
		model_clear();
		for (int i = 0; i < 8; i++)
			core_regs[i] = {next_rand(), next_rand()};
		repeat (16) @(posedge CLK);
		#10;
		RSTn = 1'b1;

		// reset values and activation
		check_outputs();
		check_word("core_req_valid", 32'(core_req_valid), 32'h0);
		check_word("S_AXI_AWREADY", 32'(S_AXI_AWREADY), 32'h0);
		check_word("S_AXI_BVALID", 32'(S_AXI_BVALID), 32'h0);
		check_word("S_AXI_ARREADY", 32'(S_AXI_ARREADY), 32'h0);
		check_word("S_AXI_RVALID", 32'(S_AXI_RVALID), 32'h0);
		check_all();
		ctrl_write(0, 0, 0, 0, 10'd5, 0, 0, 0, 1);
		check_all();

		// hart control and halt on reset
		ctrl_write(1, 0, 1, 0, 10'd0, 0, 0, 1, 1);
		check_all();
		ctrl_write(1, 0, 1, 0, 10'd3, 0, 0, 0, 1);
		ctrl_write(0, 0, 0, 0, 10'd0, 1, 0, 0, 1);
		ctrl_write(0, 0, 0, 0, 10'd0, 1, 1, 0, 1);
		ctrl_write(0, 0, 0, 0, 10'd0, 1, 0, 0, 1);
		ctrl_write(0, 0, 0, 0, 10'd0, 0, 1, 0, 1);

		// sticky status bits and summaries
		hart_in_reset = 1'b1;
		m_havereset = 1'b1;
		check_reg("dmstatus", `DM_ADDR_DMSTATUS);
		hart_in_reset = 1'b0;
		check_reg("dmstatus", `DM_ADDR_DMSTATUS);
		ctrl_write(0, 0, 0, 1, 10'd0, 0, 0, 0, 1);
		check_reg("dmstatus", `DM_ADDR_DMSTATUS);
		hart_halted = 1'b1;
		check_reg("dmstatus", `DM_ADDR_DMSTATUS);
		hart_halted = 1'b0;
		ctrl_write(0, 1, 0, 0, 10'd0, 0, 0, 0, 1);
		check_reg("dmstatus", `DM_ADDR_DMSTATUS);

		// access register reads and writes
		hart_halted = 1'b1;
		for (int i = 0; i < 6; i++) begin
			sz = next_rand() % 2 == 0 ? 3'd2 : 3'd3;
			run_cmd(8'd0, sz, 1'b1, 1'b0, 16'h1000 + 16'(i));
			check_all();
			data_write(`DM_ADDR_DATA0, next_rand());
			data_write(`DM_ADDR_DATA1, next_rand());
			run_cmd(8'd0, sz, 1'b1, 1'b1, 16'h1000 + 16'(i));
			check_all();
		end
		// no transfer, so no request may follow the command
		run_cmd(8'd0, 3'd2, 1'b0, 1'b0, 16'h1001);
		check_word("core_req_valid", 32'(core_req_valid), 32'h0);

		// command errors
		hart_halted = 1'b0;
		run_cmd(8'd0, 3'd3, 1'b1, 1'b0, 16'h1002);
		check_all();
		hart_halted = 1'b1;
		run_cmd(8'd0, 3'd3, 1'b1, 1'b0, 16'h1002);
		repeat (10) @(posedge CLK);
		#10;
		check_word("core request count", 32'(core_count), 32'(cmd_start));
		abscs_write(3'b111);
		check_all();
		run_cmd(8'd1, 3'd2, 1'b1, 1'b0, 16'h1003);
		check_all();
		abscs_write(3'b111);
		run_cmd(8'd0, 3'd4, 1'b1, 1'b0, 16'h1003);
		check_all();
		abscs_write(3'b111);
		slow_core = 1'b1;
		run_cmd(8'd0, 3'd3, 1'b1, 1'b0, 16'h1004);
		check_reg("abstractcs", `DM_ADDR_ABSTRACTCS);
		data_write(`DM_ADDR_DATA0, next_rand());
		complete_cmd();
		slow_core = 1'b0;
		check_all();
		abscs_write(3'b001);
		check_all();

		// deactivation
		ctrl_write(1, 0, 1, 0, 10'd0, 1, 0, 1, 1);
		data_write(`DM_ADDR_DATA0, next_rand());
		d = next_rand();
		data_write(`DM_ADDR_DATA1, d);
		hart_halted = 1'b0;
		run_cmd(8'd0, 3'd2, 1'b1, 1'b0, 16'h1005);
		check_all();
		ctrl_write(0, 0, 0, 0, 10'd0, 0, 0, 0, 0);
		check_all();

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: all.f
+incdir+.
dm_pkg.sv
dm_axil_slave.sv
dm_reg_decode.sv
dm_hart_ctrl.sv
dm_abstract_cmd.sv
dm_read_mux.sv
dm_top.sv
tb_dm_top.sv

// File: run_sim.sh
#!/bin/bash
# builds and runs the debug module testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --top-module tb_dm_top -f all.f -o sim_tb_dm_top
./obj_dir/sim_tb_dm_top > sim.log 2>&1 || true
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
